//--- hw/mul_cfg_pkg.sv
// configuration constants for the booth multiplier peripheral
// operand width, gather and final-add strides, derived counts
// wishbone register map and control bit positions
package mul_cfg_pkg;

  localparam int MUL_WIDTH  = 32;
  localparam int MUL_STRIDE = 8;              // multiplier bits retired per compute cycle
  localparam int BOOTH_STEP = MUL_STRIDE / 2; // radix-4 digits per compute cycle

  localparam int GATHER_LEVELS = MUL_WIDTH / MUL_STRIDE;
  localparam int CPA_STRIDE    = 16;
  localparam int CPA_LEVELS    = MUL_WIDTH / CPA_STRIDE;

  // redundant sum holds the most shifted row plus room for sign prefix and carries
  localparam int ACC_WIDTH    = MUL_STRIDE + MUL_WIDTH + 4;
  localparam int PP_WIDTH     = MUL_WIDTH + 3;
  localparam int BOOTH_DIGITS = MUL_WIDTH / 2 + 1;

  localparam int GATHER_CNT_WIDTH = (GATHER_LEVELS > 1) ? $clog2(GATHER_LEVELS) : 1;
  localparam int CPA_CNT_WIDTH    = (CPA_LEVELS > 1) ? $clog2(CPA_LEVELS) : 1;

  localparam int WB_ADDR_WIDTH = 8;

  // word offsets
  localparam logic [WB_ADDR_WIDTH-1:0] REG_OPA    = WB_ADDR_WIDTH'(0);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_OPB    = WB_ADDR_WIDTH'(1);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL   = WB_ADDR_WIDTH'(2);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_STATUS = WB_ADDR_WIDTH'(3);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_RES_LO = WB_ADDR_WIDTH'(4);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_RES_HI = WB_ADDR_WIDTH'(5);

  // ctrl word fields
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_SIGNED_BIT = 1;

endpackage

//--- hw/mul_types_pkg.sv
// shared types for the booth multiplier peripheral
// bus words, product, booth digit, core request, status word
package mul_types_pkg;

  import mul_cfg_pkg::*;

  typedef logic [MUL_WIDTH-1:0] mul_word_t;

  typedef struct packed {
    mul_word_t hi;
    mul_word_t lo;
  } mul_product_t;

  // radix-4 digit in sign/magnitude form
  typedef struct packed {
    logic negate;  // subtract the selected multiple
    logic double;  // select two times the multiplicand
    logic nonzero;
  } booth_digit_t;

  typedef struct packed {
    mul_word_t opa;
    mul_word_t opb;
    logic      is_signed;
  } mul_req_t;

  // busy in bit 0, done in bit 1
  typedef struct packed {
    logic [MUL_WIDTH-3:0] reserved;
    logic                 done;
    logic                 busy;
  } mul_status_t;

endpackage

//--- hw/booth_recoder.sv
// radix-4 booth recoder
// turns the whole multiplier into one row of booth digits
module booth_recoder
  import mul_cfg_pkg::*, mul_types_pkg::*;
(
  input  mul_word_t                       opb_i,
  input  logic                            is_signed_i,
  output booth_digit_t [BOOTH_DIGITS-1:0] digits_o
);

  logic                 ext_bit;
  logic [MUL_WIDTH+2:0] opb_ext; // two extension bits above, zero below

  assign ext_bit = is_signed_i & opb_i[MUL_WIDTH-1];
  assign opb_ext = {ext_bit, ext_bit, opb_i, 1'b0};

  // overlapping groups of three, stepping by two
  always_comb begin
    for (int i = 0; i < BOOTH_DIGITS; i++) begin
      case (opb_ext[2*i +: 3])
        3'b001, 3'b010: digits_o[i] = '{negate: 1'b0, double: 1'b0, nonzero: 1'b1}; // +1
        3'b011:         digits_o[i] = '{negate: 1'b0, double: 1'b1, nonzero: 1'b1}; // +2
        3'b100:         digits_o[i] = '{negate: 1'b1, double: 1'b1, nonzero: 1'b1}; // -2
        3'b101, 3'b110: digits_o[i] = '{negate: 1'b1, double: 1'b0, nonzero: 1'b1}; // -1
        default:        digits_o[i] = '0; // 000 and 111
      endcase
    end
  end

endmodule

//--- hw/booth_partial_product.sv
// booth partial product row selector
// picks 0, +-a or +-2a and prepends the sign-correction bits
module booth_partial_product
  import mul_cfg_pkg::*, mul_types_pkg::*;
#(
  parameter int first_row_p = 0
) (
  input  logic [MUL_WIDTH:0]              opa_i,
  input  booth_digit_t                    digit_i,
  output logic [PP_WIDTH+first_row_p-1:0] pp_o
);

  logic [MUL_WIDTH:0] opa_sel;
  logic [MUL_WIDTH:0] opa_gated;
  logic [MUL_WIDTH:0] body;
  logic               row_neg; // sign of the row value

  // one's complement only, the +1 lands in the next row
  assign opa_sel   = digit_i.negate ? ~opa_i : opa_i;
  assign opa_gated = digit_i.nonzero ? opa_sel : '0;

  // inverted 2a has a one shifted in at the bottom
  assign body = digit_i.double ? {opa_gated[MUL_WIDTH-1:0], digit_i.negate} : opa_gated;

  // a zero row is never negative whatever the operand sign
  assign row_neg = digit_i.nonzero & (digit_i.negate ^ opa_i[MUL_WIDTH]);

  if (first_row_p != 0) begin : g_first
    assign pp_o = {~row_neg, row_neg, row_neg, body};
  end else begin : g_rest
    assign pp_o = {1'b1, ~row_neg, body};
  end

endmodule

//--- hw/csa_compressor.sv
// carry-save reduction tree
// rows of 3:2 full adders, one level per recursion, down to two words
module csa_compressor
  import mul_cfg_pkg::*;
#(
  parameter int num_ops_p = 3
) (
  input  logic [num_ops_p-1:0][ACC_WIDTH-1:0] ops_i,
  output logic [ACC_WIDTH-1:0]                sum_o,
  output logic [ACC_WIDTH-1:0]                carry_o
);

  localparam int groups_lp   = num_ops_p / 3;
  localparam int rest_lp     = num_ops_p % 3;
  localparam int next_ops_lp = 2 * groups_lp + rest_lp;

  logic [next_ops_lp-1:0][ACC_WIDTH-1:0] level_n;

  // each group of three becomes a sum word and a shifted carry word
  for (genvar g = 0; g < groups_lp; g++) begin : g_row
    logic [ACC_WIDTH-1:0] maj;

    assign maj = (ops_i[3*g] & ops_i[3*g+1])
               | (ops_i[3*g] & ops_i[3*g+2])
               | (ops_i[3*g+1] & ops_i[3*g+2]);

    assign level_n[2*g]   = ops_i[3*g] ^ ops_i[3*g+1] ^ ops_i[3*g+2];
    assign level_n[2*g+1] = {maj[ACC_WIDTH-2:0], 1'b0}; // top carry falls off
  end

  // leftovers skip this level
  for (genvar r = 0; r < rest_lp; r++) begin : g_pass
    assign level_n[2*groups_lp+r] = ops_i[3*groups_lp+r];
  end

  if (num_ops_p == 3) begin : g_last
    assign sum_o   = level_n[0];
    assign carry_o = level_n[1];
  end else begin : g_next
    csa_compressor #(
      .num_ops_p(next_ops_lp)
    ) u_next (
      .ops_i  (level_n),
      .sum_o  (sum_o),
      .carry_o(carry_o)
    );
  end

endmodule

//--- hw/booth_mul_iter.sv
// iterative radix-4 booth multiplier core
// fsm and counters, operand and digit shift registers, redundant accumulator,
// tail adder for the low word, carry-select adder for the high word
module booth_mul_iter
  import mul_cfg_pkg::*, mul_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  mul_req_t     req_i,
  input  logic         req_v_i,
  output logic         req_ready_o,
  output mul_product_t res_o,
  output logic         res_v_o,
  input  logic         res_yumi_i
);

  typedef enum logic [1:0] {s_idle, s_compute, s_final_add, s_done} state_e;

  state_e                      state_r, state_n;
  logic [GATHER_CNT_WIDTH-1:0] compute_cnt_r;
  logic [CPA_CNT_WIDTH-1:0]    final_cnt_r;
  logic                        accept;
  logic                        compute_last;
  logic                        final_last;

  logic [MUL_WIDTH:0]                 opa_ext;
  logic [MUL_WIDTH:0]                 opa_r;
  booth_digit_t [BOOTH_DIGITS-1:0]    digits_n;
  booth_digit_t [MUL_WIDTH/2-1:0]     digits_r; // digit 0 goes in at accept
  logic                               carry_in_r; // +1 owed by the last digit of a step
  logic [PP_WIDTH:0]                  pp_first;
  logic [BOOTH_STEP-1:0][PP_WIDTH-1:0] pp_step;
  logic [BOOTH_STEP-1:0]              row_cin;
  logic [BOOTH_STEP+1:0][ACC_WIDTH-1:0] tree_ops;
  logic [ACC_WIDTH-1:0]               tree_sum, tree_carry;
  logic [ACC_WIDTH-1:0]               acc_sum_r, acc_carry_r;

  logic [MUL_STRIDE:0]  tail_sum;
  mul_word_t            res_lo_r, res_lo_n;
  mul_word_t            res_hi_r, res_hi_n;
  logic [CPA_STRIDE:0]  cpa_plain, cpa_plus1, cpa_sel;
  logic                 cpa_cin;
  logic                 cpa_carry_r;

  assign accept       = req_v_i & req_ready_o;
  assign compute_last = compute_cnt_r == GATHER_CNT_WIDTH'(GATHER_LEVELS - 1);
  assign final_last   = final_cnt_r == CPA_CNT_WIDTH'(CPA_LEVELS - 1);

  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle:      if (accept) state_n = s_compute;
      s_compute:   if (compute_last) state_n = s_final_add;
      s_final_add: if (final_last) state_n = s_done;
      s_done:      if (res_yumi_i) state_n = s_idle;
      default:     state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r       <= s_idle;
      compute_cnt_r <= '0;
      final_cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (accept) begin
        compute_cnt_r <= '0;
        final_cnt_r   <= '0;
      end else if (state_r == s_compute) begin
        compute_cnt_r <= compute_cnt_r + 1'b1;
      end else if (state_r == s_final_add) begin
        final_cnt_r <= final_cnt_r + 1'b1;
      end
    end
  end

  assign opa_ext = {req_i.is_signed & req_i.opa[MUL_WIDTH-1], req_i.opa};

  booth_recoder u_recoder (
    .opb_i      (req_i.opb),
    .is_signed_i(req_i.is_signed),
    .digits_o   (digits_n)
  );

  // row for digit 0 is formed straight from the request
  booth_partial_product #(
    .first_row_p(1)
  ) u_pp_first (
    .opa_i  (opa_ext),
    .digit_i(digits_n[0]),
    .pp_o   (pp_first)
  );

  for (genvar i = 0; i < BOOTH_STEP; i++) begin : g_step
    booth_partial_product #(
      .first_row_p(0)
    ) u_pp (
      .opa_i  (opa_r),
      .digit_i(digits_r[i]),
      .pp_o   (pp_step[i])
    );

    if (i == 0) begin : g_cin_first
      assign row_cin[i] = carry_in_r;
    end else begin : g_cin_prev
      assign row_cin[i] = digits_r[i-1].negate;
    end

    // row i sits two bits above its negation carry
    assign tree_ops[i] = ACC_WIDTH'({pp_step[i], 1'b0, row_cin[i]}) << (2 * i);
  end

  assign tree_ops[BOOTH_STEP]   = acc_sum_r >> MUL_STRIDE;
  assign tree_ops[BOOTH_STEP+1] = acc_carry_r >> MUL_STRIDE;

  csa_compressor #(
    .num_ops_p(BOOTH_STEP + 2)
  ) u_tree (
    .ops_i  (tree_ops),
    .sum_o  (tree_sum),
    .carry_o(tree_carry)
  );

  // retire the bottom byte of the redundant pair
  assign tail_sum = {1'b0, acc_sum_r[MUL_STRIDE-1:0]} + {1'b0, acc_carry_r[MUL_STRIDE-1:0]};
  assign res_lo_n = {tail_sum[MUL_STRIDE-1:0], res_lo_r[MUL_WIDTH-1:MUL_STRIDE]};

  // carry select over one slice of the high word
  assign cpa_plain = {1'b0, acc_sum_r[MUL_STRIDE +: CPA_STRIDE]}
                   + {1'b0, acc_carry_r[MUL_STRIDE +: CPA_STRIDE]};
  assign cpa_plus1 = cpa_plain + (CPA_STRIDE + 1)'(1);
  assign cpa_cin   = (final_cnt_r == '0) ? tail_sum[MUL_STRIDE] : cpa_carry_r;
  assign cpa_sel   = cpa_cin ? cpa_plus1 : cpa_plain;
  assign res_hi_n  = {cpa_sel[CPA_STRIDE-1:0], res_hi_r[MUL_WIDTH-1:CPA_STRIDE]};

  always_ff @(posedge clk_i) begin
    if (accept) begin
      opa_r       <= opa_ext;
      digits_r    <= digits_n[BOOTH_DIGITS-1:1];
      carry_in_r  <= digits_n[0].negate;
      acc_sum_r   <= {pp_first, MUL_STRIDE'(0)};
      acc_carry_r <= '0;
    end else if (state_r == s_compute) begin
      digits_r    <= digits_r >> (BOOTH_STEP * $bits(booth_digit_t));
      carry_in_r  <= digits_r[BOOTH_STEP-1].negate;
      acc_sum_r   <= tree_sum;
      acc_carry_r <= {tree_carry[ACC_WIDTH-1:1], tail_sum[MUL_STRIDE]}; // tail carry rides along
      res_lo_r    <= res_lo_n;
    end else if (state_r == s_final_add) begin
      if (final_cnt_r == '0) begin
        res_lo_r <= res_lo_n; // last byte of the low word
      end
      res_hi_r    <= res_hi_n;
      cpa_carry_r <= cpa_sel[CPA_STRIDE];
      acc_sum_r   <= acc_sum_r >> CPA_STRIDE;
      acc_carry_r <= acc_carry_r >> CPA_STRIDE;
    end
  end

  assign res_o       = '{hi: res_hi_r, lo: res_lo_r};
  assign res_v_o     = state_r == s_done;
  assign req_ready_o = state_r == s_idle;

endmodule

//--- hw/wb_mul_slave.sv
// wishbone classic slave for the multiplier
// operand and control registers, busy/done status, latched product,
// address decode and registered ack
module wb_mul_slave
  import mul_cfg_pkg::*, mul_types_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [WB_ADDR_WIDTH-1:0] wb_adr_i,
  input  mul_word_t                wb_dat_i,
  output mul_word_t                wb_dat_o,
  output logic                     wb_ack_o,
  output mul_req_t                 req_o,
  output logic                     req_v_o,
  input  logic                     req_ready_i,
  input  mul_product_t             res_i,
  input  logic                     res_v_i,
  output logic                     res_yumi_o
);

  logic         ack_r;
  logic         bus_req;
  logic         bus_wr;
  mul_word_t    opa_r, opb_r;
  logic         signed_r;
  logic         busy_r, done_r;
  mul_product_t res_r;
  mul_status_t  status;
  mul_word_t    rd_data;
  mul_word_t    dat_r;

  assign bus_req = wb_cyc_i & wb_stb_i & ~ack_r; // new cycle, ack follows
  assign bus_wr  = wb_cyc_i & wb_stb_i & wb_we_i & ack_r; // writes land with the ack

  // core not ready means a run is in flight, so a start then is dropped
  assign req_v_o = bus_wr & (wb_adr_i == REG_CTRL) & wb_dat_i[CTRL_START_BIT] & req_ready_i;
  assign req_o   = '{opa: opa_r, opb: opb_r, is_signed: wb_dat_i[CTRL_SIGNED_BIT]};

  assign res_yumi_o = res_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_r    <= 1'b0;
      opa_r    <= '0;
      opb_r    <= '0;
      signed_r <= 1'b0;
      busy_r   <= 1'b0;
      done_r   <= 1'b0;
      res_r    <= '0;
    end else begin
      ack_r <= bus_req;
      if (bus_wr) begin
        case (wb_adr_i)
          REG_OPA:  opa_r    <= wb_dat_i;
          REG_OPB:  opb_r    <= wb_dat_i;
          REG_CTRL: signed_r <= wb_dat_i[CTRL_SIGNED_BIT];
          default:  ; // status, result and holes are read only
        endcase
      end
      if (req_v_o) begin
        busy_r <= 1'b1;
        done_r <= 1'b0;
      end else if (res_v_i) begin
        busy_r <= 1'b0;
        done_r <= 1'b1;
        res_r  <= res_i;
      end
    end
  end

  assign status = '{reserved: '0, done: done_r, busy: busy_r};

  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      REG_OPA:    rd_data = opa_r;
      REG_OPB:    rd_data = opb_r;
      REG_CTRL:   rd_data[CTRL_SIGNED_BIT] = signed_r; // start reads back as zero
      REG_STATUS: rd_data = status;
      REG_RES_LO: rd_data = res_r.lo;
      REG_RES_HI: rd_data = res_r.hi;
      default:    rd_data = '0;
    endcase
  end

  // sampled in the request cycle, presented with the ack
  always_ff @(posedge clk_i) begin
    if (bus_req) begin
      dat_r <= rd_data;
    end
  end

  assign wb_dat_o = dat_r;
  assign wb_ack_o = ack_r;

endmodule

//--- hw/wb_mul_top.sv
// multiplier peripheral top level
// wishbone slave in front of the iterative booth core
module wb_mul_top
  import mul_cfg_pkg::*, mul_types_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [WB_ADDR_WIDTH-1:0] wb_adr_i,
  input  mul_word_t                wb_dat_i,
  output mul_word_t                wb_dat_o,
  output logic                     wb_ack_o
);

  mul_req_t     req;
  logic         req_v;
  logic         req_ready;
  mul_product_t res;
  logic         res_v;
  logic         res_yumi;

  wb_mul_slave u_slave (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .req_o      (req),
    .req_v_o    (req_v),
    .req_ready_i(req_ready),
    .res_i      (res),
    .res_v_i    (res_v),
    .res_yumi_o (res_yumi)
  );

  booth_mul_iter u_core (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (req),
    .req_v_i    (req_v),
    .req_ready_o(req_ready),
    .res_o      (res),
    .res_v_o    (res_v),
    .res_yumi_i (res_yumi)
  );

endmodule

//--- tb/tb_wb_mul.sv
// testbench for the wishbone booth multiplier peripheral
// clock, reset, wishbone bus tasks, vector table, random vectors,
// typed compare tasks and a cycle timeout
module tb_wb_mul
  import mul_cfg_pkg::*, mul_types_pkg::*;
;

  localparam int CLK_HALF     = 50;
  localparam int DRIVE_DLY    = 10; // inputs change this long after the rising edge
  localparam int RESET_CYCLES = 8;
  localparam int NUM_ROWS     = 13;
  localparam int NUM_RANDOM   = 200;
  localparam int ACK_LIMIT    = 4;
  localparam int POLL_LIMIT   = 40;
  localparam int TIMEOUT_CYCLES = (NUM_ROWS + NUM_RANDOM) * 60 + RESET_CYCLES;

  logic                     clk_i;
  logic                     reset_i;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [WB_ADDR_WIDTH-1:0] wb_adr_i;
  mul_word_t                wb_dat_i;
  mul_word_t                wb_dat_o;
  logic                     wb_ack_o;

  int cycle_cnt = 0;

  // name, opa, opb, signed flag, expected product
  string     vec_name [NUM_ROWS] = '{
    "u_zero", "u_one", "u_ones_sq", "u_max31_sq", "u_ones_x1", "u_msb_x2",
    "s_neg1_sq", "s_min_sq", "s_min_x1", "s_max_sq", "s_neg3_x7", "s_7_xneg3",
    "s_min_x_max"
  };
  mul_word_t vec_opa [NUM_ROWS] = '{
    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h7fff_ffff, 32'hffff_ffff,
    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff,
    32'hffff_fffd, 32'h0000_0007, 32'h8000_0000
  };
  mul_word_t vec_opb [NUM_ROWS] = '{
    32'h1234_5678, 32'hdead_beef, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0001,
    32'h0000_0002, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff,
    32'h0000_0007, 32'hffff_fffd, 32'h7fff_ffff
  };
  logic      vec_signed [NUM_ROWS] = '{
    1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1
  };
  logic [2*MUL_WIDTH-1:0] vec_prod [NUM_ROWS] = '{
    64'h0000_0000_0000_0000, 64'h0000_0000_dead_beef, 64'hffff_fffe_0000_0001,
    64'h3fff_ffff_0000_0001, 64'h0000_0000_ffff_ffff, 64'h0000_0001_0000_0000,
    64'h0000_0000_0000_0001, 64'h4000_0000_0000_0000, 64'hffff_ffff_8000_0000,
    64'h3fff_ffff_0000_0001, 64'hffff_ffff_ffff_ffeb, 64'hffff_ffff_ffff_ffeb,
    64'hc000_0000_8000_0000
  };

  wb_mul_top dut (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_we_i (wb_we_i),
    .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o)
  );

  initial clk_i = 1'b0;
  always #CLK_HALF clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check_word(input string name, input mul_word_t exp, input mul_word_t act);
    if (act !== exp) begin
      $display("Error: test %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_product(input string name, input mul_product_t exp,
                               input mul_product_t act);
    if (act !== exp) begin
      $display("Error: test %s expected %h_%h actual %h_%h", name, exp.hi, exp.lo,
               act.hi, act.lo);
      $display("TEST FAIL");
      $fatal(1, "product mismatch");
    end
  endtask

  task automatic check_status(input string name, input mul_status_t exp,
                              input mul_status_t act);
    if (act !== exp) begin
      $display("Error: test %s status expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "status mismatch");
    end
  endtask

  // returns one drive delay after the edge that raised ack
  task automatic wait_for_ack();
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      #DRIVE_DLY;
      n++;
    end while (!wb_ack_o && n < ACK_LIMIT);
    if (!wb_ack_o) begin
      $display("the slave never acknowledged the bus cycle");
      $display("TEST FAIL");
      $fatal(1, "missing ack");
    end
  endtask

  task automatic wb_write(input logic [WB_ADDR_WIDTH-1:0] adr, input mul_word_t dat);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wait_for_ack();
    @(posedge clk_i); // transfer completes on this edge
    #DRIVE_DLY;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_read(input logic [WB_ADDR_WIDTH-1:0] adr, output mul_word_t dat);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    wait_for_ack();
    dat = wb_dat_o; // stable for the whole ack cycle
    @(posedge clk_i);
    #DRIVE_DLY;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  // status must show busy until done comes up
  task automatic poll_done(input string name, output mul_status_t st);
    mul_word_t   rd;
    mul_status_t busy_only;
    int          n;
    busy_only = '{reserved: '0, done: 1'b0, busy: 1'b1};
    n = 0;
    do begin
      wb_read(REG_STATUS, rd);
      st = mul_status_t'(rd);
      n++;
      if (!st.done) check_status(name, busy_only, st);
    end while (!st.done && n < POLL_LIMIT);
    if (!st.done) begin
      $display("test %s: the multiplier is hung, done never set", name);
      $display("TEST FAIL");
      $fatal(1, "multiplier hung");
    end
  endtask

  function automatic mul_product_t model_product(input mul_word_t a, input mul_word_t b,
                                                 input logic s);
    logic signed [2*MUL_WIDTH-1:0] sa;
    logic signed [2*MUL_WIDTH-1:0] sb;
    logic        [2*MUL_WIDTH-1:0] p;
    if (s) begin
      sa = {{MUL_WIDTH{a[MUL_WIDTH-1]}}, a};
      sb = {{MUL_WIDTH{b[MUL_WIDTH-1]}}, b};
      p  = sa * sb;
    end else begin
      p = {{MUL_WIDTH{1'b0}}, a} * {{MUL_WIDTH{1'b0}}, b};
    end
    return mul_product_t'(p);
  endfunction

  function automatic mul_word_t ctrl_word(input logic start, input logic s);
    mul_word_t w;
    w = '0;
    w[CTRL_START_BIT]  = start;
    w[CTRL_SIGNED_BIT] = s;
    return w;
  endfunction

  task automatic read_product(output mul_product_t p);
    mul_word_t lo;
    mul_word_t hi;
    wb_read(REG_RES_LO, lo);
    wb_read(REG_RES_HI, hi);
    p = '{hi: hi, lo: lo};
  endtask

  // full operation through the bus
  task automatic run_multiply(input string name, input mul_word_t a, input mul_word_t b,
                              input logic s, input mul_product_t exp);
    mul_status_t  st;
    mul_status_t  done_only;
    mul_product_t act;
    done_only = '{reserved: '0, done: 1'b1, busy: 1'b0};
    wb_write(REG_OPA, a);
    wb_write(REG_OPB, b);
    wb_write(REG_CTRL, ctrl_word(1'b1, s));
    poll_done(name, st);
    check_status(name, done_only, st);
    read_product(act);
    check_product(name, exp, act);
  endtask

  mul_word_t    rd;
  mul_status_t  st;
  mul_product_t act;
  mul_word_t    ra;
  mul_word_t    rb;
  logic         rs;

  initial begin
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    reset_i  = 1'b1;
    void'($urandom(32'hba29_57bc));
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    reset_i = 1'b0;

    // everything reads zero out of reset
    wb_read(REG_STATUS, rd);
    check_status("reset_status", '0, mul_status_t'(rd));
    wb_read(REG_RES_LO, rd);
    check_word("reset_res_lo", '0, rd);
    wb_read(REG_RES_HI, rd);
    check_word("reset_res_hi", '0, rd);
    wb_read(REG_OPA, rd);
    check_word("reset_opa", '0, rd);
    wb_read(REG_OPB, rd);
    check_word("reset_opb", '0, rd);

    wb_write(REG_OPA, 32'ha5a5_5a5a);
    wb_write(REG_OPB, 32'h0f1e_2d3c);
    wb_read(REG_OPA, rd);
    check_word("readback_opa", 32'ha5a5_5a5a, rd);
    wb_read(REG_OPB, rd);
    check_word("readback_opb", 32'h0f1e_2d3c, rd);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_multiply(vec_name[i], vec_opa[i], vec_opb[i], vec_signed[i],
                   mul_product_t'(vec_prod[i]));
    end

    // a signed restart while busy would give -2, so the first run must stand
    wb_write(REG_OPA, 32'hffff_ffff);
    wb_write(REG_OPB, 32'h0000_0002);
    wb_write(REG_CTRL, ctrl_word(1'b1, 1'b0));
    wb_write(REG_CTRL, ctrl_word(1'b1, 1'b1));
    wb_read(REG_STATUS, rd);
    check_status("restart_busy", '{reserved: '0, done: 1'b0, busy: 1'b1}, mul_status_t'(rd));
    poll_done("restart_busy", st);
    check_status("restart_busy", '{reserved: '0, done: 1'b1, busy: 1'b0}, st);
    read_product(act);
    check_product("restart_busy", '{hi: 32'h0000_0001, lo: 32'hffff_fffe}, act);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      ra = $urandom();
      rb = $urandom();
      rs = $urandom() & 1;
      run_multiply($sformatf("rand_%0d", i), ra, rb, rs, model_product(ra, rb, rs));
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- tb.f
hw/mul_cfg_pkg.sv
hw/mul_types_pkg.sv
hw/booth_recoder.sv
hw/booth_partial_product.sv
hw/csa_compressor.sv
hw/booth_mul_iter.sv
hw/wb_mul_slave.sv
hw/wb_mul_top.sv
tb/tb_wb_mul.sv

//--- Bender.yml
package:
  name: wb_booth_mul

sources:
  - hw/mul_cfg_pkg.sv
  - hw/mul_types_pkg.sv
  - hw/booth_recoder.sv
  - hw/booth_partial_product.sv
  - hw/csa_compressor.sv
  - hw/booth_mul_iter.sv
  - hw/wb_mul_slave.sv
  - hw/wb_mul_top.sv
  - target: test
    files:
      - tb/tb_wb_mul.sv
